// File: sim.f
+incdir+include
source/log_pack_pkg.sv
source/log_skid_buf.sv
source/log_merge2.sv
source/log_packer.sv
sim/log_packer_asserts.sv
sim/log_packer_tb.sv

// File: sim/log_packer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_pack_cfg.svh"

module log_packer_tb;

  localparam int TIMEOUT    = 200;
  localparam int RAND_BEATS = 300;

  // out_ready behavior per cycle
  localparam int READY_HIGH = 0;
  localparam int READY_RAND = 1;
  localparam int READY_LOW  = 2;

  logic                  clk;
  logic                  rstn;
  logic                  in_valid;
  log_pack_pkg::lp_in_t  in_beat;
  logic                  in_ready;
  logic                  out_valid;
  log_pack_pkg::lp_out_t out_beat;
  logic                  out_ready;

  logic [31:0]           rng_state;
  int                    ready_mode;
  logic                  accept_seen;
  log_pack_pkg::lp_out_t exp_q [$];

  log_packer u_log_packer (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  bind log_packer log_packer_asserts u_asserts (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready),
    .lo_valid  (lo_valid),
    .hi_valid  (hi_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // reference packer placing valid channels back to back from bit 0
  function automatic log_pack_pkg::lp_out_t pack_model(input log_pack_pkg::lp_in_t beat);
    log_pack_pkg::lp_out_t r;
    int units [`LP_CH_CNT];
    int pos;
    int off;
    units = '{`LP_CH0_UNITS, `LP_CH1_UNITS, `LP_CH2_UNITS, `LP_CH3_UNITS};
    r = '0;
    pos = 0;
    off = 0;
    for (int c = 0; c < `LP_CH_CNT; c++) begin
      if (beat.mask[c]) begin
        for (int u = 0; u < units[c]; u++) begin
          r.data[(pos+u)*`LP_UNIT_W +: `LP_UNIT_W] = beat.data[(off+u)*`LP_UNIT_W +: `LP_UNIT_W];
        end
        pos += units[c];
      end
      off += units[c];
    end
    r.len  = log_pack_pkg::lp_len_t'(pos);
    r.mask = beat.mask;
    return r;
  endfunction

  function automatic log_pack_pkg::lp_in_t random_beat(input log_pack_pkg::lp_mask_t mask);
    log_pack_pkg::lp_in_t b;
    for (int w = 0; w < `LP_TOTAL_UNITS; w++) begin
      b.data[w*`LP_UNIT_W +: `LP_UNIT_W] = rand32();
    end
    b.mask = mask;
    return b;
  endfunction

  // nonzero mask from 1 to 15
  function automatic log_pack_pkg::lp_mask_t random_mask();
    logic [31:0] r;
    r = rand32();
    return log_pack_pkg::lp_mask_t'((r % 15) + 1);
  endfunction

  task automatic stop_with_error(input string why);
    $display("ERROR %s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  // advance to the next falling edge and update out_ready
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    r = rand32();
    case (ready_mode)
      READY_HIGH: out_ready = 1'b1;
      READY_LOW:  out_ready = 1'b0;
      default:    out_ready = r[0];
    endcase
  endtask

  // offer one beat and hold it until the DUT takes it
  task automatic send_beat(input log_pack_pkg::lp_in_t beat);
    int waited;
    waited = 0;
    accept_seen = 1'b0;
    in_valid = 1'b1;
    in_beat = beat;
    while (!accept_seen) begin
      tick();
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_error("timed out waiting for the input beat to be accepted");
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      tick();
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_error("timed out waiting for all accepted beats to come out");
      end
    end
  endtask

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////

  // registered DUT outputs read here still hold their pre-edge values
  always @(posedge clk) begin
    log_pack_pkg::lp_out_t exp_beat;
    if (!rstn) begin
      // delivered beat checked before this edge's accepted beat is queued
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_error("output beat delivered with no accepted beat outstanding");
        end else begin
          exp_beat = exp_q.pop_front();
          check_value("out_beat.mask", exp_beat.mask, out_beat.mask);
          check_value("out_beat.len", exp_beat.len, out_beat.len);
          check_value("out_beat.data", exp_beat.data, out_beat.data);
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(pack_model(in_beat));
        accept_seen = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    log_pack_pkg::lp_in_t   beat;
    log_pack_pkg::lp_mask_t sparse [5];
    logic [31:0]            r;
    int                     waited;
    int                     stuck;

    rng_state   = 32'hd4d6_7b73;
    ready_mode  = READY_HIGH;
    rstn        = 1'b1;
    in_valid    = 1'b0;
    in_beat     = '0;
    out_ready   = 1'b1;
    accept_seen = 1'b0;
    sparse      = '{4'b1010, 4'b0001, 4'b1000, 4'b0110, 4'b0101};

    // reset for three cycles then release on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("out_valid", 1'b0, out_valid);
    rstn = 1'b0;

    // in_ready high within one cycle
    waited = 0;
    while (!in_ready) begin
      tick();
      waited++;
      if (waited > 1) begin
        stop_with_error("in_ready did not rise within one cycle after reset");
      end
    end
    tick();
    check_value("out_valid", 1'b0, out_valid);

    // all channels valid gives output after exactly two edges
    beat = random_beat(4'hf);
    send_beat(beat);
    check_value("out_valid", 1'b0, out_valid);
    tick();
    check_value("out_valid", 1'b1, out_valid);
    check_value("out_beat.len", `LP_TOTAL_UNITS, out_beat.len);
    check_value("out_beat.data", beat.data, out_beat.data);
    wait_drained();

    // sparse masks
    foreach (sparse[i]) begin
      send_beat(random_beat(sparse[i]));
      wait_drained();
    end

    // long random run with random back-pressure and idle gaps
    ready_mode = READY_RAND;
    for (int n = 0; n < RAND_BEATS; n++) begin
      r = rand32();
      if (r[1:0] == 2'b00) begin
        tick();
      end
      send_beat(random_beat(random_mask()));
    end
    ready_mode = READY_HIGH;
    wait_drained();
    // nothing left in the tree once every beat is out
    check_value("out_valid", 1'b0, out_valid);

    // with the output held in_ready must fall within six beats
    ready_mode = READY_LOW;
    tick();
    stuck = 0;
    while (in_ready) begin
      if (stuck >= 6) begin
        stop_with_error("in_ready still high after six beats stuck behind out_ready low");
      end
      send_beat(random_beat(random_mask()));
      stuck++;
    end
    repeat (4) begin
      tick();
      check_value("in_ready", 1'b0, in_ready);
    end

    // release and drain in order
    ready_mode = READY_HIGH;
    wait_drained();
    check_value("out_valid", 1'b0, out_valid);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/log_packer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_pack_cfg.svh"

module log_packer_asserts (
  input logic                  clk,
  input logic                  rstn,
  input logic                  in_valid,
  input log_pack_pkg::lp_in_t  in_beat,
  input logic                  in_ready,
  input logic                  out_valid,
  input log_pack_pkg::lp_out_t out_beat,
  input logic                  out_ready,
  input logic                  lo_valid,
  input logic                  hi_valid
);

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  // a stalled input beat stays offered and unchanged
  a_in_hold: assert property (@(posedge clk) disable iff (rstn)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_beat)))
    else $error("input beat dropped or changed while in_ready was low");

  // a stalled output beat stays offered and unchanged
  a_out_hold: assert property (@(posedge clk) disable iff (rstn)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("output beat dropped or changed while out_ready was low");

  // empty beats are illegal at the input
  a_in_mask: assert property (@(posedge clk) disable iff (rstn)
    in_valid |-> (in_beat.mask != '0))
    else $error("input beat offered with an empty channel mask");

  ////////////////////////////////////////
  // tree
  ////////////////////////////////////////

  // both level 1 halves advance together
  a_lockstep: assert property (@(posedge clk) disable iff (rstn)
    lo_valid == hi_valid)
    else $error("merge_lo and merge_hi valids disagree");

  // packed length fits the output word
  a_len_max: assert property (@(posedge clk) disable iff (rstn)
    out_valid |-> (out_beat.len <= `LP_TOTAL_UNITS))
    else $error("output length larger than the packed word");

endmodule

`default_nettype wire

// File: source/log_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_pack_cfg.svh"

module log_packer (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  in_valid,
  input  log_pack_pkg::lp_in_t  in_beat,
  output logic                  in_ready,
  output logic                  out_valid,
  output log_pack_pkg::lp_out_t out_beat,
  input  logic                  out_ready
);

  localparam int UNIT_W      = `LP_UNIT_W;
  localparam int CH_CNT      = `LP_CH_CNT;
  localparam int TOTAL_UNITS = `LP_TOTAL_UNITS;

  localparam int CH0_UNITS = `LP_CH0_UNITS;
  localparam int CH1_UNITS = `LP_CH1_UNITS;
  localparam int CH2_UNITS = `LP_CH2_UNITS;
  localparam int CH3_UNITS = `LP_CH3_UNITS;

  // channel offsets in the input word, in units
  localparam int CH1_OFF = CH0_UNITS;
  localparam int CH2_OFF = CH1_OFF + CH1_UNITS;
  localparam int CH3_OFF = CH2_OFF + CH2_UNITS;

  localparam int CH_UNITS [CH_CNT] = '{CH0_UNITS, CH1_UNITS, CH2_UNITS, CH3_UNITS};
  localparam int CH_OFF   [CH_CNT] = '{0, CH1_OFF, CH2_OFF, CH3_OFF};

  // level 1 widths
  localparam int LO_UNITS = CH0_UNITS + CH1_UNITS;
  localparam int HI_UNITS = CH2_UNITS + CH3_UNITS;

  ////////////////////////////////////////
  // leaves
  ////////////////////////////////////////

  log_pack_pkg::lp_unit_t [TOTAL_UNITS-1:0] in_units;
  log_pack_pkg::lp_unit_t [TOTAL_UNITS-1:0] leaf_units;
  log_pack_pkg::lp_len_t                    leaf_len [CH_CNT];

  assign in_units = in_beat.data;

  // masked-off channels become zero records of zero length
  always_comb begin
    leaf_units = '0;
    for (int c = 0; c < CH_CNT; c++) begin
      leaf_len[c] = in_beat.mask[c] ? log_pack_pkg::lp_len_t'(CH_UNITS[c]) : '0;
      for (int u = 0; u < TOTAL_UNITS; u++) begin
        if (u >= CH_OFF[c] && u < CH_OFF[c] + CH_UNITS[c] && in_beat.mask[c]) begin
          leaf_units[u] = in_units[u];
        end
      end
    end
  end

  ////////////////////////////////////////
  // level 1
  ////////////////////////////////////////

  logic                                   lo_valid;
  logic [LO_UNITS*UNIT_W-1:0]             lo_data;
  log_pack_pkg::lp_len_t                  lo_len;
  logic [1:0]                             lo_mask;
  logic                                   lo_ready;
  logic                                   lo_a_ready;
  logic                                   lo_b_ready;

  logic                                   hi_valid;
  logic [HI_UNITS*UNIT_W-1:0]             hi_data;
  log_pack_pkg::lp_len_t                  hi_len;
  logic [1:0]                             hi_mask;
  logic                                   hi_ready;
  logic                                   hi_a_ready;
  logic                                   hi_b_ready;

  // channels 0 and 1
  log_merge2 #(
    .A_UNITS (CH0_UNITS),
    .A_CH    (1),
    .B_UNITS (CH1_UNITS),
    .B_CH    (1)
  ) merge_lo (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (in_valid),
    .a_data    (leaf_units[0 +: CH0_UNITS]),
    .a_len     (leaf_len[0]),
    .a_mask    (in_beat.mask[0]),
    .a_ready   (lo_a_ready),
    .b_valid   (in_valid),
    .b_data    (leaf_units[CH1_OFF +: CH1_UNITS]),
    .b_len     (leaf_len[1]),
    .b_mask    (in_beat.mask[1]),
    .b_ready   (lo_b_ready),
    .out_valid (lo_valid),
    .out_data  (lo_data),
    .out_len   (lo_len),
    .out_mask  (lo_mask),
    .out_ready (lo_ready)
  );

  // channels 2 and 3
  log_merge2 #(
    .A_UNITS (CH2_UNITS),
    .A_CH    (1),
    .B_UNITS (CH3_UNITS),
    .B_CH    (1)
  ) merge_hi (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (in_valid),
    .a_data    (leaf_units[CH2_OFF +: CH2_UNITS]),
    .a_len     (leaf_len[2]),
    .a_mask    (in_beat.mask[2]),
    .a_ready   (hi_a_ready),
    .b_valid   (in_valid),
    .b_data    (leaf_units[CH3_OFF +: CH3_UNITS]),
    .b_len     (leaf_len[3]),
    .b_mask    (in_beat.mask[3]),
    .b_ready   (hi_b_ready),
    .out_valid (hi_valid),
    .out_data  (hi_data),
    .out_len   (hi_len),
    .out_mask  (hi_mask),
    .out_ready (hi_ready)
  );

  // all four leaf buffers see the same beats, so these readies agree
  assign in_ready = lo_a_ready && lo_b_ready && hi_a_ready && hi_b_ready;

  ////////////////////////////////////////
  // level 2
  ////////////////////////////////////////

  log_pack_pkg::lp_data_t top_data;
  log_pack_pkg::lp_len_t  top_len;
  log_pack_pkg::lp_mask_t top_mask;

  log_merge2 #(
    .A_UNITS (LO_UNITS),
    .A_CH    (2),
    .B_UNITS (HI_UNITS),
    .B_CH    (2)
  ) merge_top (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (lo_valid),
    .a_data    (lo_data),
    .a_len     (lo_len),
    .a_mask    (lo_mask),
    .a_ready   (lo_ready),
    .b_valid   (hi_valid),
    .b_data    (hi_data),
    .b_len     (hi_len),
    .b_mask    (hi_mask),
    .b_ready   (hi_ready),
    .out_valid (out_valid),
    .out_data  (top_data),
    .out_len   (top_len),
    .out_mask  (top_mask),
    .out_ready (out_ready)
  );

  // output beat straight from the root of the tree
  always_comb begin
    out_beat.mask = top_mask;
    out_beat.len  = top_len;
    out_beat.data = top_data;
  end

endmodule

`default_nettype wire

// File: source/log_merge2.sv
`timescale 1ns/1ps
`default_nettype none

`include "log_pack_cfg.svh"

module log_merge2 #(
  parameter int A_UNITS = 1,
  parameter int A_CH    = 1,
  parameter int B_UNITS = 1,
  parameter int B_CH    = 1
) (
  input  logic                                       clk,
  input  logic                                       rstn,
  // first record, lands at bit 0
  input  logic                                       a_valid,
  input  logic [A_UNITS*`LP_UNIT_W-1:0]              a_data,
  input  log_pack_pkg::lp_len_t                      a_len,
  input  logic [A_CH-1:0]                            a_mask,
  output logic                                       a_ready,
  // second record, lands right after the first
  input  logic                                       b_valid,
  input  logic [B_UNITS*`LP_UNIT_W-1:0]              b_data,
  input  log_pack_pkg::lp_len_t                      b_len,
  input  logic [B_CH-1:0]                            b_mask,
  output logic                                       b_ready,
  // merged record
  output logic                                       out_valid,
  output logic [(A_UNITS+B_UNITS)*`LP_UNIT_W-1:0]    out_data,
  output log_pack_pkg::lp_len_t                      out_len,
  output logic [A_CH+B_CH-1:0]                       out_mask,
  input  logic                                       out_ready
);

  localparam int UNIT_W    = `LP_UNIT_W;
  localparam int A_W       = A_UNITS * UNIT_W;
  localparam int B_W       = B_UNITS * UNIT_W;
  localparam int OUT_UNITS = A_UNITS + B_UNITS;
  localparam int OUT_W     = OUT_UNITS * UNIT_W;

  // record plus its length and mask, stored together in the skid buffer
  typedef struct packed {
    logic [A_CH-1:0]       mask;
    log_pack_pkg::lp_len_t len;
    logic [A_W-1:0]        data;
  } a_rec_t;

  typedef struct packed {
    logic [B_CH-1:0]       mask;
    log_pack_pkg::lp_len_t len;
    logic [B_W-1:0]        data;
  } b_rec_t;

  a_rec_t a_in;
  a_rec_t a_q;
  b_rec_t b_in;
  b_rec_t b_q;
  logic   a_q_valid;
  logic   b_q_valid;

  // both records widened to the output size, so every index is in range
  log_pack_pkg::lp_unit_t [OUT_UNITS-1:0] a_ext;
  log_pack_pkg::lp_unit_t [OUT_UNITS-1:0] b_ext;
  log_pack_pkg::lp_unit_t [OUT_UNITS-1:0] out_units;

  ////////////////////////////////////////
  // input skid buffers
  ////////////////////////////////////////

  assign a_in = '{mask: a_mask, len: a_len, data: a_data};
  assign b_in = '{mask: b_mask, len: b_len, data: b_data};

  log_skid_buf #(
    .DATA_W ($bits(a_rec_t))
  ) u_a_buf (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (a_valid),
    .in_data   (a_in),
    .in_ready  (a_ready),
    .out_valid (a_q_valid),
    .out_data  (a_q),
    .out_ready (out_ready)
  );

  log_skid_buf #(
    .DATA_W ($bits(b_rec_t))
  ) u_b_buf (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (b_valid),
    .in_data   (b_in),
    .in_ready  (b_ready),
    .out_valid (b_q_valid),
    .out_data  (b_q),
    .out_ready (out_ready)
  );

  // both sides advance together, so the valids match
  assign out_valid = a_q_valid && b_q_valid;

  ////////////////////////////////////////
  // packing
  ////////////////////////////////////////

  assign a_ext = OUT_W'(a_q.data);
  assign b_ext = OUT_W'(b_q.data);

  // per output unit: A below a_len, then B shifted down by a_len, else zero
  always_comb begin
    int k;
    for (int j = 0; j < OUT_UNITS; j++) begin
      k = j - int'(a_q.len);
      if (j < int'(a_q.len)) begin
        out_units[j] = a_ext[j];
      end else if (k < int'(b_q.len)) begin
        out_units[j] = b_ext[k];
      end else begin
        out_units[j] = '0;
      end
    end
  end

  assign out_data = out_units;
  // max total is LP_TOTAL_UNITS, fits the length field
  assign out_len  = a_q.len + b_q.len;
  assign out_mask = {b_q.mask, a_q.mask};

endmodule

`default_nettype wire

// File: source/log_skid_buf.sv
`timescale 1ns/1ps
`default_nettype none

module log_skid_buf #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  input  logic              out_ready
);

  // second entry, only used while the output is stalled
  logic [DATA_W-1:0] spare_data;

  logic accept;
  logic pop;

  assign accept = in_valid && in_ready;
  assign pop    = out_valid && out_ready;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  // in_ready low means the spare entry is occupied
  // spare can only fill while main is full, so out_valid is high then
  always_ff @(posedge clk) begin
    if (rstn) begin
      out_valid <= 1'b0;
      in_ready  <= 1'b1;
    end else begin
      if (!in_ready) begin
        // spare moves into main on a pop, main stays full
        if (pop) begin
          in_ready <= 1'b1;
        end
      end else if (accept) begin
        if (!out_valid || out_ready) begin
          // main empty or draining this edge, take the beat directly
          out_valid <= 1'b1;
        end else begin
          // main stalled, park in spare and stop taking beats
          in_ready <= 1'b0;
        end
      end else if (pop) begin
        out_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  // main always drains first, which keeps beat order
  always_ff @(posedge clk) begin
    if (!in_ready && pop) begin
      out_data <= spare_data;
    end else if (accept && (!out_valid || out_ready)) begin
      out_data <= in_data;
    end
    if (accept && out_valid && !out_ready) begin
      spare_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: source/log_pack_pkg.sv
`default_nettype none

`include "log_pack_cfg.svh"

package log_pack_pkg;

  ////////////////////////////////////////
  // width types
  ////////////////////////////////////////

  // one alignment unit of a record
  typedef logic [`LP_UNIT_W-1:0] lp_unit_t;

  // record length counted in units
  typedef logic [`LP_LEN_W-1:0] lp_len_t;

  // bit i set when channel i carries a record
  typedef logic [`LP_CH_CNT-1:0] lp_mask_t;

  // full packed word
  typedef logic [`LP_DATA_W-1:0] lp_data_t;

  ////////////////////////////////////////
  // beat structs
  ////////////////////////////////////////

  // input beat
  // channel i at a fixed offset, sum of lower channel widths
  // slice contents don't matter when its mask bit is clear
  typedef struct packed {
    lp_mask_t mask;
    lp_data_t data;
  } lp_in_t;

  // output beat
  // records packed from bit 0 in channel order, zero above len
  typedef struct packed {
    lp_mask_t mask;
    lp_len_t  len;
    lp_data_t data;
  } lp_out_t;

endpackage

`default_nettype wire

// File: include/log_pack_cfg.svh
`ifndef LOG_PACK_CFG_SVH
`define LOG_PACK_CFG_SVH

////////////////////////////////////////
// alignment unit
////////////////////////////////////////

// every record starts and ends on a unit boundary
`define LP_UNIT_W 32

////////////////////////////////////////
// channel widths, in units
////////////////////////////////////////

`define LP_CH0_UNITS 1
`define LP_CH1_UNITS 2
`define LP_CH2_UNITS 2
`define LP_CH3_UNITS 3

// number of logging channels
`define LP_CH_CNT 4

////////////////////////////////////////
// packed output word
////////////////////////////////////////

// sum of all channel widths
`define LP_TOTAL_UNITS 8

// full packed word in bits
`define LP_DATA_W (`LP_TOTAL_UNITS * `LP_UNIT_W)

// length field, holds 0 to LP_TOTAL_UNITS
`define LP_LEN_W 4

`endif
